// ==== verilog.f ====
+incdir+tb
source/proc_pkg.sv
source/fwd_if.sv
source/fetch_stage.sv
source/decode_stage.sv
source/execute_stage.sv
source/mem_wb_stage.sv
source/processor.sv
tb/tb_processor.sv

// ==== Makefile ====
TOP = tb_processor

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f verilog.f -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q '\*\*\* PASSED \*\*\*' sim.log

clean:
	rm -rf obj_dir sim.log

// ==== tb/tb_model.svh ====
/* Instruction encoders, the architectural reference model
   and the random program generators for the core testbench */
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// --------------------
// Encoders
function automatic word_t enc_r(int rd, int rs, int rt, int sh, int alu);
    return {5'd0, 5'(rd), 5'(rs), 5'(rt), 5'(sh), 5'(alu), 2'b00};
endfunction

function automatic word_t enc_i(opcode_t op, int rd, int rs, int imm);
    return {op, 5'(rd), 5'(rs), 17'(imm)};  // Immediate truncated to 17 bits
endfunction

function automatic word_t enc_j(opcode_t op, int target);
    return {op, 27'(target)};
endfunction

// --------------------
// Reference model, one instruction per step until the halt address
function automatic void run_model(int halt);
    word_t r [32];
    word_t pc;
    word_t ir;
    word_t imm;
    word_t v;
    word_t addr;
    int    rd;
    int    rs;
    int    rt;
    int    sh;
    int    steps;
    logic  wr;
    for (int i = 0; i < 32; i++)
        r[i] = '0;
    exp_rd.delete();
    exp_val.delete();
    pc = '0;
    steps = 0;
    while (pc != word_t'(halt) && steps < 5000) begin
        ir  = imem[pc[11:0]];
        rd  = int'(ir[26:22]);
        rs  = int'(ir[21:17]);
        rt  = int'(ir[16:12]);
        sh  = int'(ir[11:7]);
        imm = {{15{ir[16]}}, ir[16:0]};     // Signed offset
        addr = r[rs] + imm;
        pc  = pc + 32'd1;                   // PC+1 is the base for branches and links
        wr  = 1'b0;
        v   = '0;
        case (opcode_t'(ir[31:27]))
            op_rtype: begin
                wr = 1'b1;
                case (ir[6:2])
                    5'd1:    v = r[rs] - r[rt];
                    5'd2:    v = r[rs] & r[rt];
                    5'd3:    v = r[rs] | r[rt];
                    5'd4:    v = r[rs] << sh;
                    5'd5:    v = word_t'($signed(r[rs]) >>> sh);
                    default: v = r[rs] + r[rt];
                endcase
            end
            op_addi: begin
                wr = 1'b1;
                v  = addr;
            end
            op_lw: begin
                wr = 1'b1;
                v  = exp_mem[addr[7:0]];   // Depth 256, low address bits only
            end
            op_sw:  exp_mem[addr[7:0]] = r[rd];
            op_bne: if (r[rd] != r[rs]) pc = pc + imm;
            op_blt: if ($signed(r[rd]) < $signed(r[rs])) pc = pc + imm;
            op_j:   pc = {5'd0, ir[26:0]};
            op_jal: begin
                wr = 1'b1;
                v  = pc;                   // Link is PC+1
                rd = 31;
                pc = {5'd0, ir[26:0]};
            end
            op_jr:  pc = r[rd];
            default: ;
        endcase
        if (wr && rd != 0) begin           // r0 never written
            r[rd] = v;
            exp_rd.push_back(reg_idx_t'(rd));
            exp_val.push_back(v);
        end
        steps++;
    end
endfunction

// --------------------
// Program generators, each ends in a self-loop at the halt address
function automatic int gen_alu(int n);
    for (int k = 0; k < n; k++) begin
        if ($urandom_range(4, 0) == 0)
            imem[k] = enc_i(op_addi, $urandom_range(7, 0), $urandom_range(7, 0),
                            $urandom_range(131071, 0));
        else                                // Few registers, so dependencies are dense
            imem[k] = enc_r($urandom_range(7, 0), $urandom_range(7, 0),
                            $urandom_range(7, 0), $urandom_range(31, 0),
                            $urandom_range(5, 0));
    end
    imem[n] = enc_j(op_j, n);
    return n;
endfunction

function automatic int gen_mem(int groups);
    int a;
    int b;
    int k;
    for (int g = 0; g < groups; g++) begin
        a = $urandom_range(7, 1);
        b = $urandom_range(7, 1);
        k = 3 * g;
        case ($urandom_range(2, 0))
            0: begin                        // Store right after its producer
                imem[k]     = enc_i(op_addi, a, 0, $urandom_range(131071, 0));
                imem[k + 1] = enc_i(op_sw, a, 0, $urandom_range(255, 0));
                imem[k + 2] = enc_i(op_lw, b, 0, $urandom_range(255, 0));
            end
            1: begin                        // Load-use pair
                imem[k]     = enc_i(op_lw, a, 0, $urandom_range(255, 0));
                imem[k + 1] = enc_r(b, a, a, 0, alu_add);
                imem[k + 2] = enc_i(op_sw, b, 0, $urandom_range(255, 0));
            end
            default: begin                  // Load then store of the same register
                imem[k]     = enc_i(op_lw, a, 0, $urandom_range(255, 0));
                imem[k + 1] = enc_i(op_sw, a, 0, $urandom_range(255, 0));
                imem[k + 2] = enc_i(op_lw, b, a, 0);  // Loaded value as a base
            end
        endcase
    end
    imem[3 * groups] = enc_j(op_j, 3 * groups);
    return 3 * groups;
endfunction

function automatic int gen_branch(int blocks);
    int      v1;
    int      v2;
    int      k;
    opcode_t op;
    for (int g = 0; g < blocks; g++) begin
        k  = 5 * g;
        v1 = $urandom_range(131071, 0);
        v2 = ($urandom_range(3, 0) == 0) ? v1 : $urandom_range(131071, 0);
        op = ($urandom_range(1, 0) == 1) ? op_bne : op_blt;
        imem[k]     = enc_i(op_addi, 1, 0, v1);
        imem[k + 1] = enc_i(op_addi, 2, 0, v2);
        if ($urandom_range(1, 0) == 1)
            imem[k + 2] = enc_i(op, 1, 2, 2);  // Skip the next two when taken
        else
            imem[k + 2] = enc_i(op, 2, 1, 2);
        imem[k + 3] = enc_i(op_addi, 3, 0, $urandom_range(131071, 0));
        imem[k + 4] = enc_i(op_addi, 4, 0, $urandom_range(131071, 0));
    end
    imem[5 * blocks] = enc_j(op_j, 5 * blocks);
    return 5 * blocks;
endfunction

function automatic int gen_jal();
    for (int k = 0; k < 4; k++) begin
        imem[3 * k]     = enc_i(op_addi, k + 1, 0, $urandom_range(131071, 0));
        imem[3 * k + 1] = enc_j(op_jal, 13);
        imem[3 * k + 2] = enc_i(op_addi, 10, 31, 0);  // Copy of the link
    end
    imem[12] = enc_j(op_j, 16);             // Jump over the subroutine
    imem[13] = enc_r(5, 1, 2, 0, alu_add);
    imem[14] = enc_r(6, 5, 0, 3, alu_sll);
    imem[15] = enc_i(op_jr, 31, 0, 0);      // Return
    imem[16] = enc_j(op_j, 16);
    return 16;
endfunction

`endif

// ==== tb/tb_processor.sv ====
/* Core testbench: clock, reset, memory and register file models,
   DUT, write-stream compare and watchdog */
`timescale 1ns/1ps
`default_nettype none

module tb_processor import proc_pkg::*; ();
    localparam int total_instr = 201 + 61 + 61 + 17;  // All four programs with halts

    logic     clock;
    logic     rst_n;
    word_t    address_imem;
    word_t    q_imem;
    word_t    address_dmem;
    word_t    data;
    logic     wren;
    word_t    q_dmem;
    logic     ctrl_writeEnable;
    reg_idx_t ctrl_writeReg;
    reg_idx_t ctrl_readRegA;
    reg_idx_t ctrl_readRegB;
    word_t    data_writeReg;
    word_t    data_readRegA;
    word_t    data_readRegB;

    word_t    imem [4096];
    word_t    dmem [256];
    word_t    regs [32];
    word_t    exp_mem [256];     // Reference data memory image
    reg_idx_t exp_rd [$];        // Expected write stream
    word_t    exp_val [$];
    int       wr_count;

    `include "tb_model.svh"

    // --------------------
    // Models
    assign q_imem        = imem[address_imem[11:0]];
    assign q_dmem        = dmem[address_dmem[7:0]];
    assign data_readRegA = regs[ctrl_readRegA];  // Asynchronous reads
    assign data_readRegB = regs[ctrl_readRegB];

    always @(posedge clock)
        if (wren) dmem[address_dmem[7:0]] <= data;

    always @(negedge clock)   // Write on falling edge so decode sees it
        if (ctrl_writeEnable) regs[ctrl_writeReg] <= data_writeReg;

    processor #(.imem_addr_bits(12)) dut_i (
        .clock (clock), .rst_n (rst_n),
        .address_imem (address_imem), .q_imem (q_imem),
        .address_dmem (address_dmem), .data (data), .wren (wren), .q_dmem (q_dmem),
        .ctrl_writeEnable (ctrl_writeEnable), .ctrl_writeReg (ctrl_writeReg),
        .ctrl_readRegA (ctrl_readRegA), .ctrl_readRegB (ctrl_readRegB),
        .data_writeReg (data_writeReg),
        .data_readRegA (data_readRegA), .data_readRegB (data_readRegB)
    );

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    // --------------------
    // Error reporting
    task automatic abort_run(string why);
        $display("%s", why);
        $display("*** FAILED ***");
        $fatal(1, "stopped at first error");
    endtask

    task automatic report_mismatch(string sig, word_t got, word_t want);
        abort_run($sformatf("Fail at %0t: %s is %h, expected %h", $time, sig, got, want));
    endtask

    // Compare each register write against the reference stream
    always @(negedge clock) begin
        if (rst_n && ctrl_writeEnable) begin
            assert (exp_rd.size() != 0)
                else abort_run("Register write seen after the expected stream ended");
            assert (ctrl_writeReg == exp_rd[0])
                else report_mismatch("ctrl_writeReg", word_t'(ctrl_writeReg), word_t'(exp_rd[0]));
            assert (data_writeReg == exp_val[0])
                else report_mismatch("data_writeReg", data_writeReg, exp_val[0]);
            void'(exp_rd.pop_front());
            void'(exp_val.pop_front());
            wr_count++;
        end
    end

    initial begin   // Watchdog
        repeat (total_instr * 3 + 50) @(posedge clock);
        abort_run("Timeout: the programs did not reach their halt address in time");
    end

    // Load a program under reset, then run it to its halt loop
    task automatic run_program(int kind);
        int halt;
        int exp_count;
        @(negedge clock);
        rst_n = 1'b0;
        for (int i = 0; i < 4096; i++)
            imem[i] = '0;                         // Zero word is a nop
        for (int i = 0; i < 32; i++)
            regs[i] <= '0;
        for (int i = 0; i < 256; i++) begin
            dmem[i]    <= (word_t'(i) * 32'h9E3779B1) ^ 32'h0BADF00D;
            exp_mem[i] = (word_t'(i) * 32'h9E3779B1) ^ 32'h0BADF00D;
        end
        case (kind)
            0:       halt = gen_alu(200);
            1:       halt = gen_mem(20);
            2:       halt = gen_branch(12);
            default: halt = gen_jal();
        endcase
        run_model(halt);
        exp_count = exp_rd.size();
        wr_count  = 0;
        repeat (4) @(negedge clock);
        assert (address_imem == reset_pc)
            else report_mismatch("address_imem", address_imem, 32'd0);
        rst_n = 1'b1;
        for (int k = 0; k < 4; k++) begin         // Pipeline still filling
            if (k < 3)
                assert (!wren) else report_mismatch("wren", word_t'(wren), 32'd0);
            assert (!ctrl_writeEnable)
                else report_mismatch("ctrl_writeEnable", word_t'(ctrl_writeEnable), 32'd0);
            @(negedge clock);
        end
        // Halt loop refetches its own address every third cycle
        do begin
            while (address_imem != word_t'(halt))
                @(negedge clock);
            repeat (3) @(negedge clock);
        end while (address_imem != word_t'(halt));
        repeat (6) @(negedge clock);              // Let trailing stores land
        assert (wr_count == exp_count)
            else report_mismatch("write count", word_t'(wr_count), word_t'(exp_count));
        for (int i = 0; i < 256; i++)
            assert (dmem[i] == exp_mem[i])
                else report_mismatch($sformatf("dmem[%0d]", i), dmem[i], exp_mem[i]);
        if (kind == 3)                            // Last jal sits at address 10
            assert (regs[31] == 32'd11) else report_mismatch("r31", regs[31], 32'd11);
    endtask

    // --------------------
    // Main sequence
    initial begin
        void'($urandom(37));
        rst_n = 1'b0;
        wr_count = 0;
        for (int i = 0; i < 4096; i++)
            imem[i] = '0;
        for (int i = 0; i < 256; i++)
            dmem[i] <= '0;
        for (int i = 0; i < 32; i++)
            regs[i] <= '0;
        run_program(0);   // ALU and addi chains
        run_program(1);   // Loads and stores
        run_program(2);   // Branches
        run_program(3);   // jal and jr
        $display("*** PASSED ***");
        $finish;
    end
endmodule

`default_nettype wire

// ==== source/processor.sv ====
/* Five-stage pipelined core; register file and both memories are external */
`timescale 1ns/1ps
`default_nettype none

module processor import proc_pkg::*; #(
    parameter int imem_addr_bits = 12
) (
    input  logic     clock,
    input  logic     rst_n,
    // Instruction memory
    output word_t    address_imem,
    input  word_t    q_imem,
    // Data memory
    output word_t    address_dmem,
    output word_t    data,
    output logic     wren,
    input  word_t    q_dmem,
    // Register file
    output logic     ctrl_writeEnable,
    output reg_idx_t ctrl_writeReg,
    output reg_idx_t ctrl_readRegA,
    output reg_idx_t ctrl_readRegB,
    output word_t    data_writeReg,
    input  word_t    data_readRegA,
    input  word_t    data_readRegB
);
    logic  stall;
    logic  redirect;
    word_t redirect_pc;
    word_t fd_pc;
    word_t fd_ir;
    word_t dx_pc;
    word_t dx_a;
    word_t dx_b;
    word_t dx_imm;
    ctrl_t dx_ctrl;
    word_t xm_value;
    word_t xm_store;
    ctrl_t xm_ctrl;

    fwd_if fwd ();  // Memory and write-back results back to decode and execute

    fetch_stage #(
        .imem_addr_bits (imem_addr_bits)
    ) u_fetch (
        .clock       (clock),
        .rst_n       (rst_n),
        .stall       (stall),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .imem_q      (q_imem),
        .imem_addr   (address_imem),
        .fd_pc       (fd_pc),
        .fd_ir       (fd_ir)
    );

    decode_stage u_decode (
        .clock    (clock),
        .rst_n    (rst_n),
        .redirect (redirect),
        .fd_pc    (fd_pc),
        .fd_ir    (fd_ir),
        .rf_a     (data_readRegA),
        .rf_b     (data_readRegB),
        .rf_sel_a (ctrl_readRegA),
        .rf_sel_b (ctrl_readRegB),
        .fwd      (fwd.dec_sink),
        .stall    (stall),
        .dx_pc    (dx_pc),
        .dx_a     (dx_a),
        .dx_b     (dx_b),
        .dx_imm   (dx_imm),
        .dx_ctrl  (dx_ctrl)
    );

    execute_stage u_execute (
        .clock       (clock),
        .rst_n       (rst_n),
        .dx_pc       (dx_pc),
        .dx_a        (dx_a),
        .dx_b        (dx_b),
        .dx_imm      (dx_imm),
        .dx_ctrl     (dx_ctrl),
        .fwd         (fwd.exec_sink),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .xm_value    (xm_value),
        .xm_store    (xm_store),
        .xm_ctrl     (xm_ctrl)
    );

    mem_wb_stage u_mem_wb (
        .clock     (clock),
        .rst_n     (rst_n),
        .xm_value  (xm_value),
        .xm_store  (xm_store),
        .xm_ctrl   (xm_ctrl),
        .dmem_q    (q_dmem),
        .dmem_addr (address_dmem),
        .dmem_data (data),
        .dmem_wren (wren),
        .rf_we     (ctrl_writeEnable),
        .rf_waddr  (ctrl_writeReg),
        .rf_wdata  (data_writeReg),
        .fwd       (fwd.source)
    );
endmodule

`default_nettype wire

// ==== source/mem_wb_stage.sv ====
/* Data memory access, store-data bypass, memory/write-back register
   and the write-back select */
`timescale 1ns/1ps
`default_nettype none

module mem_wb_stage import proc_pkg::*; (
    input  logic     clock,
    input  logic     rst_n,
    input  word_t    xm_value,
    input  word_t    xm_store,
    input  ctrl_t    xm_ctrl,
    input  word_t    dmem_q,
    output word_t    dmem_addr,
    output word_t    dmem_data,
    output logic     dmem_wren,
    output logic     rf_we,
    output reg_idx_t rf_waddr,
    output word_t    rf_wdata,
    fwd_if.source    fwd
);
    reg_idx_t xm_rd;
    logic     store_hit;
    ctrl_t    mw_ctrl;
    word_t    mw_value;
    word_t    mw_load;

    assign xm_rd = xm_ctrl[ctrl_rd_hi:ctrl_rd_lo];

    // --------------------
    // Data memory
    assign dmem_addr = xm_value;
    assign dmem_wren = xm_ctrl[ctrl_mwe];
    // Load right before a store of the same register
    assign store_hit = rf_we && (rf_waddr == xm_ctrl[ctrl_rb_hi:ctrl_rb_lo]);
    assign dmem_data = store_hit ? rf_wdata : xm_store;

    // Memory/write-back register
    always_ff @(posedge clock) begin
        if (!rst_n)
            mw_ctrl <= '0;
        else
            mw_ctrl <= xm_ctrl;
    end

    always_ff @(posedge clock) begin
        mw_value <= xm_value;
        mw_load  <= dmem_q;   // Asynchronous read, captured here
    end

    // --------------------
    // Write-back
    assign rf_waddr = mw_ctrl[ctrl_rd_hi:ctrl_rd_lo];
    assign rf_we    = mw_ctrl[ctrl_rwe] && (rf_waddr != '0);  // r0 stays zero
    assign rf_wdata = mw_ctrl[ctrl_m2r] ? mw_load : mw_value;

    // Bypass sources
    assign fwd.xm_we      = xm_ctrl[ctrl_rwe] && !xm_ctrl[ctrl_m2r] && (xm_rd != '0);
    assign fwd.xm_rd      = xm_rd;
    assign fwd.xm_value   = xm_value;
    assign fwd.mw_we      = rf_we;
    assign fwd.mw_rd      = rf_waddr;
    assign fwd.mw_value   = rf_wdata;
    assign fwd.xm_is_load = xm_ctrl[ctrl_m2r];
    assign fwd.xm_rd_load = xm_rd;
endmodule

`default_nettype wire

// ==== source/execute_stage.sv ====
/* Execute: operand bypass, ALU, branch and jump resolution,
   and the execute/memory register */
`timescale 1ns/1ps
`default_nettype none

module execute_stage import proc_pkg::*; (
    input  logic     clock,
    input  logic     rst_n,
    input  word_t    dx_pc,      // PC+1 of this instruction
    input  word_t    dx_a,
    input  word_t    dx_b,
    input  word_t    dx_imm,
    input  ctrl_t    dx_ctrl,
    fwd_if.exec_sink fwd,
    output logic     redirect,
    output word_t    redirect_pc,
    output word_t    xm_value,
    output word_t    xm_store,
    output ctrl_t    xm_ctrl
);
    reg_idx_t ra;
    reg_idx_t rb;
    alu_op_t  alu_op;
    shamt_t   shamt;
    logic     xm_hit_a;
    logic     xm_hit_b;
    logic     mw_hit_a;
    logic     mw_hit_b;
    word_t    op_a;
    word_t    op_b;
    word_t    alu_b;
    word_t    alu_res;
    logic     ne;
    logic     lt;
    logic     taken;
    ctrl_t    ctrl_out;

    assign ra     = dx_ctrl[ctrl_ra_hi:ctrl_ra_lo];
    assign rb     = dx_ctrl[ctrl_rb_hi:ctrl_rb_lo];
    assign alu_op = alu_op_t'(dx_ctrl[ctrl_alu_hi:ctrl_alu_lo]);
    assign shamt  = dx_ctrl[ctrl_sh_hi:ctrl_sh_lo];

    // --------------------
    // Operand bypass
    // Youngest producer first; a pending load hides any older write-back
    assign xm_hit_a = fwd.xm_we && (fwd.xm_rd == ra);
    assign xm_hit_b = fwd.xm_we && (fwd.xm_rd == rb);
    assign mw_hit_a = fwd.mw_we && (fwd.mw_rd == ra) &&
                      !(fwd.xm_is_load && fwd.xm_rd_load == ra);
    assign mw_hit_b = fwd.mw_we && (fwd.mw_rd == rb) &&
                      !(fwd.xm_is_load && fwd.xm_rd_load == rb);

    assign op_a  = xm_hit_a ? fwd.xm_value : mw_hit_a ? fwd.mw_value : dx_a;
    assign op_b  = xm_hit_b ? fwd.xm_value : mw_hit_b ? fwd.mw_value : dx_b;
    assign alu_b = dx_ctrl[ctrl_use_imm] ? dx_imm : op_b;  // addi, lw, sw

    // --------------------
    // ALU
    always_comb begin
        case (alu_op)
            alu_add: alu_res = op_a + alu_b;
            alu_sub: alu_res = op_a - alu_b;
            alu_and: alu_res = op_a & alu_b;
            alu_or:  alu_res = op_a | alu_b;
            alu_sll: alu_res = op_a << shamt;
            alu_sra: alu_res = word_t'($signed(op_a) >>> shamt);
            default: alu_res = op_a + alu_b;
        endcase
    end

    // Compare flags off the subtract, overflow-safe signed less-than
    assign ne = (alu_res != '0);
    assign lt = (op_a[31] & ~alu_b[31]) | (~(op_a[31] ^ alu_b[31]) & alu_res[31]);

    // --------------------
    // Branch and jump resolution
    assign taken    = (dx_ctrl[ctrl_bne] && ne) || (dx_ctrl[ctrl_blt] && lt);
    assign redirect = taken || dx_ctrl[ctrl_jimm] || dx_ctrl[ctrl_jr];

    always_comb begin
        if (dx_ctrl[ctrl_jr])
            redirect_pc = op_a;            // jr to $rd
        else if (dx_ctrl[ctrl_jimm])
            redirect_pc = dx_imm;          // Absolute target
        else
            redirect_pc = dx_pc + dx_imm;  // PC+1+offset
    end

    // jal writes its link into r31
    always_comb begin
        ctrl_out = dx_ctrl;
        if (dx_ctrl[ctrl_link])
            ctrl_out[ctrl_rd_hi:ctrl_rd_lo] = link_reg;
    end

    // Execute/memory register
    always_ff @(posedge clock) begin
        if (!rst_n)
            xm_ctrl <= '0;
        else
            xm_ctrl <= ctrl_out;
    end

    always_ff @(posedge clock) begin
        xm_value <= dx_ctrl[ctrl_link] ? dx_pc : alu_res;
        xm_store <= op_b;                  // Store data after bypass
    end
endmodule

`default_nettype wire

// ==== source/decode_stage.sv ====
/* Instruction decode: field extraction, control word, register selects,
   immediate extension, load-use stall and the decode/execute register */
`timescale 1ns/1ps
`default_nettype none

module decode_stage import proc_pkg::*; (
    input  logic     clock,
    input  logic     rst_n,
    input  logic     redirect,
    input  word_t    fd_pc,
    input  word_t    fd_ir,
    input  word_t    rf_a,
    input  word_t    rf_b,
    output reg_idx_t rf_sel_a,
    output reg_idx_t rf_sel_b,
    fwd_if.dec_sink  fwd,
    output logic     stall,
    output word_t    dx_pc,
    output word_t    dx_a,
    output word_t    dx_b,
    output word_t    dx_imm,
    output ctrl_t    dx_ctrl
);
    opcode_t  opcode;
    reg_idx_t rd;
    reg_idx_t rs;
    reg_idx_t rt;
    shamt_t   shamt;
    alu_op_t  alu_sel;
    logic     is_rtype;
    logic     is_addi;
    logic     is_lw;
    logic     is_sw;
    logic     is_bne;
    logic     is_blt;
    logic     is_j;
    logic     is_jal;
    logic     is_jr;
    logic     use_a;             // Operand a really read
    logic     use_b;             // Operand b read as an ALU input
    reg_idx_t dx_rd;
    ctrl_t    ctrl;
    word_t    imm;
    word_t    a_val;
    word_t    b_val;

    assign opcode = opcode_t'(fd_ir[op_hi:op_lo]);
    assign rd     = fd_ir[rd_hi:rd_lo];
    assign rs     = fd_ir[rs_hi:rs_lo];
    assign rt     = fd_ir[rt_hi:rt_lo];
    assign shamt  = fd_ir[sh_hi:sh_lo];

    assign is_rtype = (opcode == op_rtype);
    assign is_addi  = (opcode == op_addi);
    assign is_lw    = (opcode == op_lw);
    assign is_sw    = (opcode == op_sw);
    assign is_bne   = (opcode == op_bne);
    assign is_blt   = (opcode == op_blt);
    assign is_j     = (opcode == op_j);
    assign is_jal   = (opcode == op_jal);
    assign is_jr    = (opcode == op_jr);

    // --------------------
    // Register read selects
    assign rf_sel_a = (is_bne || is_blt || is_jr) ? rd : rs;  // Compares and jr use rd
    assign rf_sel_b = (is_bne || is_blt) ? rs :
                      is_sw ? rd : rt;                        // sw data comes from rd

    assign use_a = is_rtype || is_addi || is_lw || is_sw || is_bne || is_blt || is_jr;
    assign use_b = is_rtype || is_bne || is_blt;              // Not sw data, bypassed later

    // Catch a write-back landing this very cycle
    assign a_val = (fwd.mw_we && fwd.mw_rd == rf_sel_a) ? fwd.mw_value : rf_a;
    assign b_val = (fwd.mw_we && fwd.mw_rd == rf_sel_b) ? fwd.mw_value : rf_b;

    // Target for j/jal, signed offset otherwise
    assign imm = (is_j || is_jal) ? {{(31 - target_msb){1'b0}}, fd_ir[target_msb:0]}
                                  : {{(31 - imm_msb){fd_ir[imm_msb]}}, fd_ir[imm_msb:0]};

    assign alu_sel = is_rtype ? alu_op_t'(fd_ir[alu_hi:alu_lo]) :
                     (is_bne || is_blt) ? alu_sub : alu_add;

    // --------------------
    // Control word
    always_comb begin
        ctrl = '0;
        ctrl[ctrl_rd_hi:ctrl_rd_lo]   = rd;
        ctrl[ctrl_ra_hi:ctrl_ra_lo]   = use_a ? rf_sel_a : '0;
        ctrl[ctrl_rb_hi:ctrl_rb_lo]   = (use_b || is_sw) ? rf_sel_b : '0;
        ctrl[ctrl_alu_hi:ctrl_alu_lo] = alu_sel;
        ctrl[ctrl_sh_hi:ctrl_sh_lo]   = shamt;
        ctrl[ctrl_use_imm] = is_addi || is_lw || is_sw;
        ctrl[ctrl_rwe]     = ((is_rtype || is_addi || is_lw) && rd != '0) || is_jal;
        ctrl[ctrl_mwe]     = is_sw;
        ctrl[ctrl_m2r]     = is_lw;
        ctrl[ctrl_bne]     = is_bne;
        ctrl[ctrl_blt]     = is_blt;
        ctrl[ctrl_jimm]    = is_j || is_jal;
        ctrl[ctrl_jr]      = is_jr;
        ctrl[ctrl_link]    = is_jal;  // rd becomes r31 in execute
    end

    // Load in execute whose result is needed here
    assign dx_rd = dx_ctrl[ctrl_rd_hi:ctrl_rd_lo];
    assign stall = dx_ctrl[ctrl_m2r] && (dx_rd != '0) &&
                   ((use_a && dx_rd == rf_sel_a) || (use_b && dx_rd == rf_sel_b));

    // --------------------
    // Decode/execute register
    always_ff @(posedge clock) begin
        if (!rst_n)
            dx_ctrl <= '0;
        else if (redirect || stall)
            dx_ctrl <= '0;           // Bubble
        else
            dx_ctrl <= ctrl;
    end

    always_ff @(posedge clock) begin
        dx_pc  <= fd_pc;
        dx_a   <= a_val;
        dx_b   <= b_val;
        dx_imm <= imm;
    end
endmodule

`default_nettype wire

// ==== source/fetch_stage.sv ====
/* Program counter, next-PC select and the fetch/decode register */
`timescale 1ns/1ps
`default_nettype none

module fetch_stage import proc_pkg::*; #(
    parameter int imem_addr_bits = 12
) (
    input  logic  clock,
    input  logic  rst_n,
    input  logic  stall,        // Load-use hold from decode
    input  logic  redirect,     // Taken branch or jump in execute
    input  word_t redirect_pc,
    input  word_t imem_q,
    output word_t imem_addr,
    output word_t fd_pc,        // PC+1 of the fetched instruction
    output word_t fd_ir
);
    // Keeps the PC inside the instruction memory
    localparam word_t pc_mask = word_t'((64'd1 << imem_addr_bits) - 64'd1);

    word_t pc;
    word_t pc_inc;

    assign pc_inc    = (pc + 32'd1) & pc_mask;  // Wraps at the memory size
    assign imem_addr = pc;

    always_ff @(posedge clock) begin
        if (!rst_n)
            pc <= reset_pc;
        else if (redirect)         // Redirect wins over stall
            pc <= redirect_pc;
        else if (!stall)
            pc <= pc_inc;
    end

    // --------------------
    // Fetch/decode register
    always_ff @(posedge clock) begin
        if (!rst_n)
            fd_ir <= '0;           // Zero word decodes as a bubble
        else if (redirect)
            fd_ir <= '0;           // Squash the wrong-path fetch
        else if (!stall)
            fd_ir <= imem_q;
    end

    always_ff @(posedge clock) begin
        if (!stall || redirect)
            fd_pc <= pc_inc;
    end
endmodule

`default_nettype wire

// ==== source/fwd_if.sv ====
/* Bypass bundle from the memory and write-back stages */
`timescale 1ns/1ps
`default_nettype none

interface fwd_if import proc_pkg::*; ();
    logic     xm_we;       // Memory-stage result is valid, never for loads
    reg_idx_t xm_rd;
    word_t    xm_value;
    logic     mw_we;       // Final write-back
    reg_idx_t mw_rd;
    word_t    mw_value;
    logic     xm_is_load;  // Load sitting in memory stage
    reg_idx_t xm_rd_load;

    modport source (output xm_we, xm_rd, xm_value, mw_we, mw_rd, mw_value,
                    xm_is_load, xm_rd_load);
    modport exec_sink (input xm_we, xm_rd, xm_value, mw_we, mw_rd, mw_value,
                       xm_is_load, xm_rd_load);
    modport dec_sink (input mw_we, mw_rd, mw_value);
endinterface

`default_nettype wire

// ==== source/proc_pkg.sv ====
/* Shared types, instruction field positions, opcode and ALU encodings,
   and the packed control word that travels down the pipeline */
`default_nettype none

package proc_pkg;

    // --------------------
    // Basic types
    typedef logic [31:0] word_t;     // Data word, address or instruction
    typedef logic [4:0]  reg_idx_t;  // Register index
    typedef logic [4:0]  shamt_t;    // Shift amount

    typedef enum logic [4:0] {
        op_rtype = 5'd0,
        op_j     = 5'd1,
        op_bne   = 5'd2,
        op_jal   = 5'd3,
        op_jr    = 5'd4,
        op_addi  = 5'd5,
        op_blt   = 5'd6,
        op_sw    = 5'd7,
        op_lw    = 5'd8
    } opcode_t;

    typedef enum logic [4:0] {
        alu_add = 5'd0,
        alu_sub = 5'd1,
        alu_and = 5'd2,
        alu_or  = 5'd3,
        alu_sll = 5'd4,
        alu_sra = 5'd5
    } alu_op_t;

    // --------------------
    // Instruction fields
    parameter int op_hi      = 31;
    parameter int op_lo      = 27;
    parameter int rd_hi      = 26;
    parameter int rd_lo      = 22;
    parameter int rs_hi      = 21;
    parameter int rs_lo      = 17;
    parameter int rt_hi      = 16;
    parameter int rt_lo      = 12;
    parameter int sh_hi      = 11;
    parameter int sh_lo      = 7;
    parameter int alu_hi     = 6;
    parameter int alu_lo     = 2;
    parameter int imm_msb    = 16;  // Immediate is [16:0], sign-extended
    parameter int target_msb = 26;  // Jump target is [26:0], zero-extended

    // --------------------
    // Control word layout
    // rd, both source selects, ALU code, shift, then one-bit flags
    parameter int ctrl_width   = 34;
    parameter int ctrl_rd_hi   = 33;
    parameter int ctrl_rd_lo   = 29;
    parameter int ctrl_ra_hi   = 28;  // Source of operand a, 0 when unused
    parameter int ctrl_ra_lo   = 24;
    parameter int ctrl_rb_hi   = 23;  // Source of operand b or store data
    parameter int ctrl_rb_lo   = 19;
    parameter int ctrl_alu_hi  = 18;
    parameter int ctrl_alu_lo  = 14;
    parameter int ctrl_sh_hi   = 13;
    parameter int ctrl_sh_lo   = 9;
    parameter int ctrl_use_imm = 8;
    parameter int ctrl_rwe     = 7;
    parameter int ctrl_mwe     = 6;
    parameter int ctrl_m2r     = 5;
    parameter int ctrl_bne     = 4;
    parameter int ctrl_blt     = 3;
    parameter int ctrl_jimm    = 2;   // j or jal
    parameter int ctrl_jr      = 1;
    parameter int ctrl_link    = 0;   // jal writes PC+1

    typedef logic [ctrl_width-1:0] ctrl_t;  // All zero is a bubble

    parameter reg_idx_t link_reg = 5'd31;
    parameter word_t    reset_pc = 32'd0;

endpackage

`default_nettype wire
